// File: list.f
src/isa_pkg.sv
src/core_pkg.sv
src/inst_memory.sv
src/control_unit.sv
src/program_counter.sv
src/register_bank.sv
src/alu.sv
src/muu.sv
src/data_memory.sv
src/mips_single_cycle.sv
tb/mips_assertions.sv
tb/mips_tb.sv

// File: run.sh
#!/bin/bash
# Build with Verilator, run, and look for the pass line in the log
verilator --binary --timing --assert -f list.f --top-module mips_tb -o sim_mips \
	> build.log 2>&1 \
	&& ./obj_dir/sim_mips | tee sim.log \
	&& grep -qx "Test completed successfully" sim.log \
	&& echo "PASS" \
	|| { echo "FAIL (see build.log and sim.log)"; exit 1; }

// File: src/alu.sv
`timescale 1ns/10ps
module alu import isa_pkg::*, core_pkg::*; (
	input  logic [31:0] rs_data,
	input  logic [31:0] rt_data,
	input  instr_t      instr,
	input  alu_op_t     alu_op,
	input  logic        alu_src_imm,
	input  logic        imm_signed,
	input  logic        branch_on_equal,
	output logic [31:0] result,
	output logic        zero,      // Branch taken
	output logic        movn_ok,   // rt nonzero
	output logic [31:0] operand_b
);

	logic [15:0] imm;
	logic [31:0] imm_ext;
	logic [4:0]  shamt;

	assign imm     = instr.i_fmt.imm;
	assign shamt   = instr.r_fmt.shamt;
	assign imm_ext = imm_signed ? {{16{imm[15]}}, imm} : {16'd0, imm};

	assign operand_b = alu_src_imm ? imm_ext : rt_data;

	always_comb begin
		case (alu_op)
			alu_add:    result = rs_data + operand_b;
			alu_sub:    result = rs_data - operand_b;
			alu_and:    result = rs_data & operand_b;
			alu_or:     result = rs_data | operand_b;
			alu_xor:    result = rs_data ^ operand_b;
			alu_nor:    result = ~(rs_data | operand_b);
			alu_slt:    result = {31'd0, $signed(rs_data) < $signed(operand_b)};
			alu_sltu:   result = {31'd0, rs_data < operand_b};
			alu_sll:    result = operand_b << shamt;
			alu_srl:    result = operand_b >> shamt;
			alu_sra:    result = $signed(operand_b) >>> shamt; // Keeps the sign
			alu_lui:    result = {operand_b[15:0], 16'd0};
			alu_pass_a: result = rs_data;
			default:    result = 32'd0;
		endcase
	end

	// Compares registers directly since operand B holds the branch offset
	assign zero    = branch_on_equal ? (rs_data == rt_data) : (rs_data != rt_data);
	assign movn_ok = (rt_data != 32'd0);

endmodule

// File: src/control_unit.sv
`timescale 1ns/10ps
module control_unit import isa_pkg::*, core_pkg::*; (
	input  instr_t   instr,
	output pc_src_t  pc_src,
	output reg_dst_t reg_dst,
	output wb_src_t  wb_src,
	output alu_op_t  alu_op,
	output logic     alu_src_imm,     // Operand B from the immediate
	output logic     imm_signed,
	output logic     branch_on_equal, // beq when set, bne otherwise
	output logic     mem_write,
	output logic     mem_byte,
	output logic     reg_write,
	output logic     conditional_write, // movn
	output muu_op_t  muu_op
);

	always_comb begin
		// No-op unless decoded below
		pc_src            = pc_seq;
		reg_dst           = dst_rd;
		wb_src            = wb_alu;
		alu_op            = alu_add;
		alu_src_imm       = 1'b0;
		imm_signed        = 1'b1;
		branch_on_equal   = 1'b0;
		mem_write         = 1'b0;
		mem_byte          = 1'b0;
		reg_write         = 1'b0;
		conditional_write = 1'b0;
		muu_op            = muu_none;

		case (instr.r_fmt.opcode)
			op_rtype: begin
				reg_write = 1'b1; // Most R-type ops write rd
				case (instr.r_fmt.funct)
					fn_add, fn_addu: alu_op = alu_add; // No overflow trap
					fn_sub, fn_subu: alu_op = alu_sub;
					fn_and:  alu_op = alu_and;
					fn_or:   alu_op = alu_or;
					fn_xor:  alu_op = alu_xor;
					fn_nor:  alu_op = alu_nor;
					fn_slt:  alu_op = alu_slt;
					fn_sltu: alu_op = alu_sltu;
					fn_sll:  alu_op = alu_sll;
					fn_srl:  alu_op = alu_srl;
					fn_sra:  alu_op = alu_sra;
					fn_jr: begin
						pc_src    = pc_jump_reg;
						reg_write = 1'b0;
					end
					fn_jalr: begin
						pc_src = pc_jump_reg;
						wb_src = wb_link;
					end
					fn_movn: begin
						alu_op            = alu_pass_a;
						conditional_write = 1'b1; // Gated by rt != 0
					end
					fn_mult, fn_multu: begin
						muu_op    = (instr.r_fmt.funct == fn_mult) ? muu_mult : muu_multu;
						reg_write = 1'b0; // Result lands in hi/lo
					end
					fn_mfhi, fn_mflo: begin
						muu_op = muu_read;
						wb_src = wb_muu;
					end
					default: reg_write = 1'b0; // Unknown funct
				endcase
			end
			op_addi, op_addiu, op_slti, op_andi, op_ori, op_xori, op_lui: begin
				reg_dst     = dst_rt;
				alu_src_imm = 1'b1;
				reg_write   = 1'b1;
				case (instr.i_fmt.opcode)
					op_slti: alu_op = alu_slt;
					op_andi: alu_op = alu_and;
					op_ori:  alu_op = alu_or;
					op_xori: alu_op = alu_xor;
					op_lui:  alu_op = alu_lui;
					default: alu_op = alu_add;
				endcase
				// Logical immediates are zero extended
				imm_signed = !(instr.i_fmt.opcode inside {op_andi, op_ori, op_xori});
			end
			op_lw, op_lb: begin
				reg_dst     = dst_rt;
				alu_src_imm = 1'b1; // Base plus signed offset
				wb_src      = wb_mem;
				mem_byte    = (instr.i_fmt.opcode == op_lb);
				reg_write   = 1'b1;
			end
			op_sw, op_sb: begin
				alu_src_imm = 1'b1;
				mem_write   = 1'b1;
				mem_byte    = (instr.i_fmt.opcode == op_sb);
			end
			op_beq, op_bne: begin
				pc_src          = pc_branch;
				alu_src_imm     = 1'b1; // Operand B carries the offset to the PC
				branch_on_equal = (instr.i_fmt.opcode == op_beq);
			end
			op_j: pc_src = pc_jump;
			op_jal: begin
				pc_src    = pc_jump;
				reg_dst   = dst_ra;
				wb_src    = wb_link;
				reg_write = 1'b1;
			end
			default: ; // Unknown opcode stays a no-op
		endcase
	end

endmodule

// File: src/core_pkg.sv
package core_pkg;

	// ALU operations
	typedef enum logic [3:0] {
		alu_add,
		alu_sub,
		alu_and,
		alu_or,
		alu_xor,
		alu_nor,
		alu_slt,
		alu_sltu,
		alu_sll,
		alu_srl,
		alu_sra,
		alu_lui,
		alu_pass_a // movn passes rs through
	} alu_op_t;

	typedef enum logic [1:0] {pc_seq, pc_branch, pc_jump, pc_jump_reg} pc_src_t;
	typedef enum logic [1:0] {wb_alu, wb_mem, wb_link, wb_muu} wb_src_t;
	typedef enum logic [1:0] {dst_rt, dst_rd, dst_ra} reg_dst_t;
	typedef enum logic [1:0] {muu_none, muu_mult, muu_multu, muu_read} muu_op_t;

	// Memory sizes in 32-bit words
	localparam int imem_words  = 64;
	localparam int dmem_words  = 64;
	localparam int imem_addr_w = $clog2(imem_words);
	localparam int dmem_addr_w = $clog2(dmem_words);

endpackage

// File: src/data_memory.sv
`timescale 1ns/10ps
module data_memory import core_pkg::*; (
	input  logic        clk,
	input  logic [31:0] address,
	input  logic [31:0] write_data,
	input  logic        write_enable,
	input  logic        byte_mode,  // lb/sb
	output logic [31:0] read_data
);

	logic [31:0]            mem [dmem_words];
	logic [dmem_addr_w-1:0] index;
	logic [1:0]             lane;    // Byte within the word, little-endian
	logic [31:0]            word;
	logic [7:0]             rd_byte;

	assign index = address[dmem_addr_w+1:2];
	assign lane  = address[1:0];

	always_ff @(posedge clk) begin
		if (write_enable) begin
			if (byte_mode)
				mem[index][lane*8 +: 8] <= write_data[7:0]; // Other lanes untouched
			else
				mem[index] <= write_data;
		end
	end

	assign word    = mem[index];
	assign rd_byte = word[lane*8 +: 8];

	// Byte loads are sign extended
	assign read_data = byte_mode ? {{24{rd_byte[7]}}, rd_byte} : word;

endmodule

// File: src/inst_memory.sv
`timescale 1ns/10ps
module inst_memory import isa_pkg::*, core_pkg::*; (
	input  logic                   clk,
	input  logic                   load_en,
	input  logic [imem_addr_w-1:0] load_addr, // Word address
	input  logic [31:0]            load_data,
	input  logic [31:0]            address,   // Byte address from the PC
	output instr_t                 instr
);

	logic [31:0] mem [imem_words];

	// Program load, independent of reset
	always_ff @(posedge clk) begin
		if (load_en)
			mem[load_addr] <= load_data;
	end

	assign instr = mem[address[imem_addr_w+1:2]]; // Fetch within the same cycle

endmodule

// File: src/isa_pkg.sv
package isa_pkg;

	// R-type field layout
	typedef struct packed {
		logic [5:0] opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm; // Sign or zero extended by the ALU
	} i_fmt_t;

	typedef struct packed {
		logic [5:0]  opcode;
		logic [25:0] target; // Word index inside the current 256 MB region
	} j_fmt_t;

	// Same 32-bit word seen through each format
	typedef union packed {
		r_fmt_t r_fmt;
		i_fmt_t i_fmt;
		j_fmt_t j_fmt;
	} instr_t;

	// Opcodes
	localparam logic [5:0] op_rtype = 6'h00;
	localparam logic [5:0] op_j     = 6'h02;
	localparam logic [5:0] op_jal   = 6'h03;
	localparam logic [5:0] op_beq   = 6'h04;
	localparam logic [5:0] op_bne   = 6'h05;
	localparam logic [5:0] op_addi  = 6'h08;
	localparam logic [5:0] op_addiu = 6'h09;
	localparam logic [5:0] op_slti  = 6'h0a;
	localparam logic [5:0] op_andi  = 6'h0c;
	localparam logic [5:0] op_ori   = 6'h0d;
	localparam logic [5:0] op_xori  = 6'h0e;
	localparam logic [5:0] op_lui   = 6'h0f;
	localparam logic [5:0] op_lb    = 6'h20;
	localparam logic [5:0] op_lw    = 6'h23;
	localparam logic [5:0] op_sb    = 6'h28;
	localparam logic [5:0] op_sw    = 6'h2b;

	// Funct codes for op_rtype
	localparam logic [5:0] fn_sll   = 6'h00;
	localparam logic [5:0] fn_srl   = 6'h02;
	localparam logic [5:0] fn_sra   = 6'h03;
	localparam logic [5:0] fn_jr    = 6'h08;
	localparam logic [5:0] fn_jalr  = 6'h09;
	localparam logic [5:0] fn_movn  = 6'h0b;
	localparam logic [5:0] fn_mfhi  = 6'h10;
	localparam logic [5:0] fn_mflo  = 6'h12;
	localparam logic [5:0] fn_mult  = 6'h18;
	localparam logic [5:0] fn_multu = 6'h19;
	localparam logic [5:0] fn_add   = 6'h20;
	localparam logic [5:0] fn_addu  = 6'h21;
	localparam logic [5:0] fn_sub   = 6'h22;
	localparam logic [5:0] fn_subu  = 6'h23;
	localparam logic [5:0] fn_and   = 6'h24;
	localparam logic [5:0] fn_or    = 6'h25;
	localparam logic [5:0] fn_xor   = 6'h26;
	localparam logic [5:0] fn_nor   = 6'h27;
	localparam logic [5:0] fn_slt   = 6'h2a;
	localparam logic [5:0] fn_sltu  = 6'h2b;

endpackage

// File: src/mips_single_cycle.sv
`timescale 1ns/10ps
module mips_single_cycle import isa_pkg::*, core_pkg::*; (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   imem_load_en,   // Program load while reset is held
	input  logic [imem_addr_w-1:0] imem_load_addr,
	input  logic [31:0]            imem_load_data,
	output logic [31:0]            pc,
	output logic                   reg_write_en,   // Register write trace
	output logic [4:0]             reg_write_reg,
	output logic [31:0]            reg_write_data,
	output logic                   mem_write_en,   // Memory write trace
	output logic [31:0]            mem_write_addr,
	output logic [31:0]            mem_write_data,
	output logic [31:0]            hi,
	output logic [31:0]            lo
);

	instr_t   instr;
	pc_src_t  pc_src;
	reg_dst_t reg_dst;
	wb_src_t  wb_src;
	alu_op_t  alu_op;
	muu_op_t  muu_op;
	logic     alu_src_imm, imm_signed, branch_on_equal;
	logic     mem_write, mem_byte, reg_write, conditional_write;

	logic [31:0] rs_data, rt_data;  // Register file read ports
	logic [31:0] result, operand_b; // operand_b doubles as the branch offset
	logic        zero, movn_ok;
	logic [31:0] load_data, muu_out, return_address;

	// Destination register
	always_comb begin
		case (reg_dst)
			dst_rt:  reg_write_reg = instr.i_fmt.rt;
			dst_rd:  reg_write_reg = instr.r_fmt.rd;
			default: reg_write_reg = 5'd31; // Link register for jal
		endcase
	end

	// Writeback source
	always_comb begin
		case (wb_src)
			wb_alu:  reg_write_data = result;
			wb_mem:  reg_write_data = load_data;
			wb_link: reg_write_data = return_address;
			default: reg_write_data = muu_out;
		endcase
	end

	// Commit only what the register file will really take
	assign reg_write_en = reg_write & ~reset & (~conditional_write | movn_ok)
		& (reg_write_reg != 5'd0);
	assign mem_write_en   = mem_write & ~reset; // No stores while the program loads
	assign mem_write_addr = result;
	assign mem_write_data = rt_data;

	inst_memory inst_memory_i (
		.clk(clk), .load_en(imem_load_en), .load_addr(imem_load_addr),
		.load_data(imem_load_data), .address(pc), .instr(instr)
	);

	control_unit control_unit_i (
		.instr(instr), .pc_src(pc_src), .reg_dst(reg_dst), .wb_src(wb_src),
		.alu_op(alu_op), .alu_src_imm(alu_src_imm), .imm_signed(imm_signed),
		.branch_on_equal(branch_on_equal), .mem_write(mem_write), .mem_byte(mem_byte),
		.reg_write(reg_write), .conditional_write(conditional_write), .muu_op(muu_op)
	);

	program_counter program_counter_i (
		.clk(clk), .reset(reset), .pc_src(pc_src), .zero(zero),
		.branch_offset(operand_b), .reg_target(rs_data),
		.jump_target(instr.j_fmt.target), .pc(pc), .return_address(return_address)
	);

	register_bank register_bank_i (
		.clk(clk), .reset(reset), .read_reg1(instr.r_fmt.rs), .read_reg2(instr.r_fmt.rt),
		.write_reg(reg_write_reg), .write_enable(reg_write), .conditional_write(conditional_write),
		.movn_ok(movn_ok), .write_data(reg_write_data),
		.read_data1(rs_data), .read_data2(rt_data)
	);

	alu alu_i (
		.rs_data(rs_data), .rt_data(rt_data), .instr(instr), .alu_op(alu_op),
		.alu_src_imm(alu_src_imm), .imm_signed(imm_signed), .branch_on_equal(branch_on_equal),
		.result(result), .zero(zero), .movn_ok(movn_ok), .operand_b(operand_b)
	);

	muu muu_i (
		.clk(clk), .reset(reset), .rs(rs_data), .rt(rt_data), .muu_op(muu_op),
		.funct_hi(instr.r_fmt.funct == fn_mfhi), .out(muu_out), .hi(hi), .lo(lo)
	);

	data_memory data_memory_i (
		.clk(clk), .address(result), .write_data(rt_data), .write_enable(mem_write_en),
		.byte_mode(mem_byte), .read_data(load_data)
	);

endmodule

// File: src/muu.sv
`timescale 1ns/10ps
module muu import core_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  logic [31:0] rs,
	input  logic [31:0] rt,
	input  muu_op_t     muu_op,
	input  logic        funct_hi, // mfhi when set, mflo otherwise
	output logic [31:0] out,
	output logic [31:0] hi,
	output logic [31:0] lo
);

	logic [63:0] prod_s; // Signed product for mult
	logic [63:0] prod_u; // Unsigned product for multu

	assign prod_s = $signed(rs) * $signed(rt);
	assign prod_u = {32'd0, rs} * {32'd0, rt};

	always_ff @(posedge clk) begin
		if (reset) begin
			hi <= 32'd0;
			lo <= 32'd0;
		end else begin
			case (muu_op)
				muu_mult:  {hi, lo} <= prod_s;
				muu_multu: {hi, lo} <= prod_u;
				default: ; // Reads and no-ops keep hi/lo
			endcase
		end
	end

	// Result only when a move-from is decoded
	always_comb begin
		if (muu_op == muu_read)
			out = funct_hi ? hi : lo;
		else
			out = 32'd0;
	end

endmodule

// File: src/program_counter.sv
`timescale 1ns/10ps
module program_counter import core_pkg::*; (
	input  logic        clk,
	input  logic        reset,
	input  pc_src_t     pc_src,
	input  logic        zero,          // Branch condition from the ALU
	input  logic [31:0] branch_offset, // Sign-extended word offset
	input  logic [31:0] reg_target,    // rs for jr/jalr
	input  logic [25:0] jump_target,
	output logic [31:0] pc,
	output logic [31:0] return_address
);

	logic [31:0] pc_plus4;
	logic [31:0] next_pc;

	assign pc_plus4       = pc + 32'd4;
	assign return_address = pc + 32'd8; // Link skips the slot after the jump

	always_comb begin
		case (pc_src)
			pc_branch:   next_pc = zero ? pc_plus4 + {branch_offset[29:0], 2'b00} : pc_plus4;
			pc_jump:     next_pc = {pc_plus4[31:28], jump_target, 2'b00};
			pc_jump_reg: next_pc = reg_target;
			default:     next_pc = pc_plus4;
		endcase
	end

	always_ff @(posedge clk) begin
		if (reset)
			pc <= 32'd0; // Fetch restarts at address zero
		else
			pc <= next_pc;
	end

endmodule

// File: src/register_bank.sv
`timescale 1ns/10ps
module register_bank (
	input  logic        clk,
	input  logic        reset,
	input  logic [4:0]  read_reg1,
	input  logic [4:0]  read_reg2,
	input  logic [4:0]  write_reg,
	input  logic        write_enable,
	input  logic        conditional_write, // Write depends on movn_ok
	input  logic        movn_ok,
	input  logic [31:0] write_data,
	output logic [31:0] read_data1,
	output logic [31:0] read_data2
);

	logic [31:0] regs [32];
	logic        do_write;

	assign do_write = write_enable & (~conditional_write | movn_ok) & (write_reg != 5'd0);

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < 32; i++)
				regs[i] <= 32'd0;
		end else if (do_write) begin
			regs[write_reg] <= write_data;
		end
	end

	// $zero reads as zero whatever is stored
	assign read_data1 = (read_reg1 == 5'd0) ? 32'd0 : regs[read_reg1];
	assign read_data2 = (read_reg2 == 5'd0) ? 32'd0 : regs[read_reg2];

endmodule

// File: tb/mips_assertions.sv
`timescale 1ns/10ps
module mips_assertions (
	input logic        clk,
	input logic        reset,
	input logic [31:0] pc,
	input logic        reg_write_en,
	input logic [4:0]  reg_write_reg,
	input logic        mem_write_en
);

	// Fetch address always on a word boundary
	pc_aligned: assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
		else $error("pc %h is not word aligned", pc);

	// Trace ports stay quiet while the core is held in reset
	quiet_in_reset: assert property (@(posedge clk) reset |-> !reg_write_en && !mem_write_en)
		else $error("write trace active during reset");

	// $zero never shows up as a destination
	no_zero_dest: assert property (@(posedge clk) disable iff (reset)
		reg_write_en |-> reg_write_reg != 5'd0)
		else $error("register write to $zero on the trace");

endmodule

bind mips_single_cycle mips_assertions mips_assertions_i (
	.clk(clk), .reset(reset), .pc(pc), .reg_write_en(reg_write_en),
	.reg_write_reg(reg_write_reg), .mem_write_en(mem_write_en)
);

// File: tb/mips_tb.sv
`timescale 1ns/10ps
module mips_tb import isa_pkg::*, core_pkg::*; ();

	logic                   clk, reset, imem_load_en;
	logic [imem_addr_w-1:0] imem_load_addr;
	logic [31:0]            imem_load_data;
	logic [31:0]            pc, reg_write_data, mem_write_addr, mem_write_data, hi, lo;
	logic                   reg_write_en, mem_write_en;
	logic [4:0]             reg_write_reg;

	// Program image by word address, and one table row per executed instruction
	logic [31:0] prog [imem_words];
	logic [31:0] row_pc [64], row_instr [64], row_rval [64], row_maddr [64], row_mval [64];
	logic [4:0]  row_rreg [64];
	logic        row_rwe [64], row_mwe [64];
	int          n_rows, seed, passed, failed;

	mips_single_cycle dut_i (
		.clk(clk), .reset(reset), .imem_load_en(imem_load_en),
		.imem_load_addr(imem_load_addr), .imem_load_data(imem_load_data), .pc(pc),
		.reg_write_en(reg_write_en), .reg_write_reg(reg_write_reg),
		.reg_write_data(reg_write_data), .mem_write_en(mem_write_en),
		.mem_write_addr(mem_write_addr), .mem_write_data(mem_write_data), .hi(hi), .lo(lo)
	);

	always #20 clk = ~clk; // 40 ns period

	function automatic logic [31:0] r_word(int rs, int rt, int rd, int sh, logic [5:0] fn);
		return {op_rtype, rs[4:0], rt[4:0], rd[4:0], sh[4:0], fn};
	endfunction

	function automatic logic [31:0] i_word(logic [5:0] op, int rs, int rt, int imm);
		return {op, rs[4:0], rt[4:0], imm[15:0]};
	endfunction

	function automatic logic [31:0] j_word(logic [5:0] op, int target);
		return {op, target[25:0]};
	endfunction

	task automatic push_row(int at, logic [31:0] word, logic rwe, int rreg, logic [31:0] rval,
		logic mwe, logic [31:0] maddr, logic [31:0] mval);
		prog[at / 4]      = word; // Placed at its own address
		row_pc[n_rows]    = at;
		row_instr[n_rows] = word;
		row_rwe[n_rows]   = rwe;
		row_rreg[n_rows]  = rreg[4:0];
		row_rval[n_rows]  = rval;
		row_mwe[n_rows]   = mwe;
		row_maddr[n_rows] = maddr;
		row_mval[n_rows]  = mval;
		n_rows++;
	endtask

	task automatic reg_row(int at, logic [31:0] word, int rreg, logic [31:0] rval);
		push_row(at, word, 1'b1, rreg, rval, 1'b0, 32'd0, 32'd0);
	endtask

	task automatic mem_row(int at, logic [31:0] word, logic [31:0] maddr, logic [31:0] mval);
		push_row(at, word, 1'b0, 0, 32'd0, 1'b1, maddr, mval);
	endtask

	task automatic quiet_row(int at, logic [31:0] word);
		push_row(at, word, 1'b0, 0, 32'd0, 1'b0, 32'd0, 32'd0);
	endtask

	task automatic build_table;
		int          ia, ib;
		logic [31:0] r1, r2;
		logic [63:0] ps, pu;
		// Skipped slots hold addiu $27 with the address, so a wrong path shows on the trace
		for (int a = 0; a < imem_words; a++)
			prog[a] = i_word(op_addiu, 0, 27, 'hf000 + a);
		ia = $random(seed);
		ib = $random(seed);
		ia[15] = 1'b1; // Forces a negative addi immediate
		ib[15] = 1'b1; // Top bit set so zero extension matters for ori
		r1 = {{16{ia[15]}}, ia[15:0]}; // addi sign extends
		r2 = {16'd0, ib[15:0]};        // ori zero extends
		ps = {{32{r1[31]}}, r1} * {{32{r2[31]}}, r2};
		pu = 64'h87650000 * 64'hff876500;
		reg_row(0, i_word(op_addi, 0, 1, ia), 1, r1);
		reg_row(4, i_word(op_ori, 0, 2, ib), 2, r2);
		reg_row(8, r_word(1, 2, 3, 0, fn_add), 3, r1 + r2);
		reg_row(12, r_word(1, 2, 4, 0, fn_sub), 4, r1 - r2);
		reg_row(16, r_word(1, 2, 5, 0, fn_and), 5, r1 & r2);
		reg_row(20, r_word(1, 2, 6, 0, fn_or), 6, r1 | r2);
		reg_row(24, r_word(1, 2, 7, 0, fn_xor), 7, r1 ^ r2);
		reg_row(28, r_word(1, 2, 8, 0, fn_nor), 8, ~(r1 | r2));
		reg_row(32, r_word(1, 2, 9, 0, fn_slt), 9, ($signed(r1) < $signed(r2)) ? 32'd1 : 32'd0);
		reg_row(36, r_word(1, 2, 10, 0, fn_sltu), 10, (r1 < r2) ? 32'd1 : 32'd0);
		reg_row(40, i_word(op_lui, 0, 11, 'h8765), 11, 32'h87650000);
		reg_row(44, r_word(0, 11, 12, 4, fn_sll), 12, 32'h76500000);
		reg_row(48, r_word(0, 11, 13, 8, fn_srl), 13, 32'h00876500);
		reg_row(52, r_word(0, 11, 14, 8, fn_sra), 14, 32'hff876500); // Sign fills in
		reg_row(56, i_word(op_addiu, 0, 15, 64), 15, 32'd64);
		mem_row(60, i_word(op_sw, 15, 11, 4), 32'd68, 32'h87650000);
		mem_row(64, i_word(op_sb, 15, 2, 9), 32'd73, r2); // Trace shows all of rt
		reg_row(68, i_word(op_lw, 15, 16, 4), 16, 32'h87650000);
		reg_row(72, i_word(op_lb, 15, 17, 9), 17, {{24{ib[7]}}, ib[7:0]});
		reg_row(76, i_word(op_lb, 15, 18, 7), 18, 32'hffffff87); // Top lane of the sw word
		quiet_row(80, i_word(op_beq, 1, 1, 2));  // Taken, to 92
		quiet_row(92, i_word(op_bne, 1, 1, 5));  // Not taken
		quiet_row(96, i_word(op_beq, 0, 15, 3)); // Not taken
		quiet_row(100, i_word(op_bne, 0, 15, 1)); // Taken, to 108
		quiet_row(108, j_word(op_j, 30));
		reg_row(120, j_word(op_jal, 33), 31, 32'd128); // Link is pc+8
		reg_row(132, i_word(op_addiu, 0, 19, 148), 19, 32'd148);
		quiet_row(136, r_word(19, 0, 0, 0, fn_jr));
		reg_row(148, i_word(op_addiu, 0, 21, 164), 21, 32'd164);
		reg_row(152, r_word(21, 0, 20, 0, fn_jalr), 20, 32'd160);
		quiet_row(164, r_word(1, 2, 0, 0, fn_mult));
		reg_row(168, r_word(0, 0, 22, 0, fn_mfhi), 22, ps[63:32]);
		reg_row(172, r_word(0, 0, 23, 0, fn_mflo), 23, ps[31:0]);
		quiet_row(176, r_word(11, 14, 0, 0, fn_multu));
		reg_row(180, r_word(0, 0, 24, 0, fn_mfhi), 24, pu[63:32]);
		reg_row(184, r_word(0, 0, 25, 0, fn_mflo), 25, pu[31:0]);
		quiet_row(188, r_word(11, 0, 26, 0, fn_movn)); // rt is $zero, no write
		reg_row(192, r_word(11, 15, 26, 0, fn_movn), 26, 32'h87650000);
	endtask

	// Returns at a rising clock edge
	task automatic wait_rise;
		logic last;
		int   waited;
		last   = clk;
		waited = 0;
		while (!(last === 1'b0 && clk === 1'b1)) begin
			last = clk;
			#1;
			waited++;
			if (waited > 100) begin
				$display("Timeout: no rising clock edge within 100 ns at %0t", $time);
				$display("Test failed");
				$finish;
			end
		end
	endtask

	initial begin
		logic bad;
		seed = 79679;
		clk = 1'b0;
		reset = 1'b1;
		imem_load_en = 1'b0;
		imem_load_addr = '0;
		imem_load_data = 32'd0;
		n_rows = 0;
		passed = 0;
		failed = 0;
		build_table();
		// Program goes in under reset, then reset holds 10 more cycles
		for (int a = 0; a < imem_words; a++) begin
			wait_rise();
			#2;
			imem_load_en   = 1'b1;
			imem_load_addr = a[imem_addr_w-1:0];
			imem_load_data = prog[a];
		end
		wait_rise();
		#2 imem_load_en = 1'b0;
		for (int k = 0; k < 10; k++)
			wait_rise();
		#36;
		bad = 1'b0;
		assert (pc == 32'd0 && hi == 32'd0 && lo == 32'd0 && !reg_write_en && !mem_write_en)
		else begin
			$display("[ERROR] %0t: reset state pc %h hi %h lo %h rwe %b mwe %b", $time,
				pc, hi, lo, reg_write_en, mem_write_en);
			bad = 1'b1;
		end
		$display("reset state: %s", bad ? "FAIL" : "ok");
		if (bad)
			failed++;
		else
			passed++;
		wait_rise();
		#2 reset = 1'b0;
		for (int i = 0; i < n_rows; i++) begin
			#34; // Just before the edge that commits row i
			bad = 1'b0;
			assert (pc == row_pc[i]) else begin
				$display("[ERROR] %0t: row %0d pc %h, expected %h", $time, i, pc, row_pc[i]);
				bad = 1'b1;
			end
			assert (reg_write_en == row_rwe[i] && (!row_rwe[i] ||
				(reg_write_reg == row_rreg[i] && reg_write_data == row_rval[i]))) else begin
				$display("[ERROR] %0t: row %0d reg write %b $%0d=%h, expected %b $%0d=%h",
					$time, i, reg_write_en, reg_write_reg, reg_write_data,
					row_rwe[i], row_rreg[i], row_rval[i]);
				bad = 1'b1;
			end
			assert (mem_write_en == row_mwe[i] && (!row_mwe[i] ||
				(mem_write_addr == row_maddr[i] && mem_write_data == row_mval[i]))) else begin
				$display("[ERROR] %0t: row %0d mem write %b [%h]=%h, expected %b [%h]=%h",
					$time, i, mem_write_en, mem_write_addr, mem_write_data,
					row_mwe[i], row_maddr[i], row_mval[i]);
				bad = 1'b1;
			end
			$display("row %0d pc %h instr %h: %s", i, row_pc[i], row_instr[i],
				bad ? "FAIL" : "ok");
			if (bad)
				failed++;
			else
				passed++;
			wait_rise();
			#2;
		end
		$display("%0d tests, %0d passed, %0d failed", passed + failed, passed, failed);
		if (failed == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
